// File: vlog.f
src/na_pkg.sv
src/na_fifo.sv
src/na_conf_regs.sv
src/na_bus_ctrl.sv
src/mp_tx.sv
src/mp_rx.sv
src/na_ct_top.sv
testbench/tb_checker.sv
testbench/na_ct_asserts.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_top -o sim_tb_top

out=$(./obj_dir/sim_tb_top)
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
   exit 0
fi
exit 1

// File: testbench/tb_top.sv
// Testbench top with clock, reset, bus and link stimulus, test sequence, checker and DUT
`timescale 1ns/1ps

module tb_top;

   import na_pkg::*;

   logic       clk;
   logic       rst;
   bus_req_t   bus_req;
   bus_rsp_t   bus_rsp;
   flit_t      out_flit;
   logic       out_valid;
   logic       out_ready = 1'b1;                   // Sink starts ready
   flit_t      in_flit;
   logic       in_valid;
   logic       in_ready;
   logic       irq;
   logic       rand_ready;                         // Sink stalls at random when set
   logic       test_end;
   logic [2:0] test_num;
   int         err_cnt;
   int         chk_cnt;
   int         cycle_cnt = 0;

   na_ct_top dut0 (
      .clk             (clk),
      .rst_i           (rst),
      .bus_req_i       (bus_req),
      .bus_rsp_o       (bus_rsp),
      .noc_out_flit_o  (out_flit),
      .noc_out_valid_o (out_valid),
      .noc_out_ready_i (out_ready),
      .noc_in_flit_i   (in_flit),
      .noc_in_valid_i  (in_valid),
      .noc_in_ready_o  (in_ready),
      .irq_o           (irq)
   );

   tb_checker chk0 (
      .clk         (clk),
      .rst_i       (rst),
      .bus_req_i   (bus_req),
      .bus_rsp_i   (bus_rsp),
      .out_flit_i  (out_flit),
      .out_valid_i (out_valid),
      .out_ready_i (out_ready),
      .in_flit_i   (in_flit),
      .in_valid_i  (in_valid),
      .in_ready_i  (in_ready),
      .irq_i       (irq),
      .test_end_i  (test_end),
      .test_num_i  (test_num),
      .err_cnt_o   (err_cnt),
      .chk_cnt_o   (chk_cnt)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;                           // 10 ns period

   // Limit covers all six tests, the stall test takes a few hundred cycles
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == 2000) begin
         $display("timeout, run did not finish within 2000 cycles");
         $display("TEST FAIL");
         $finish;
      end
   end

   always @(negedge clk) begin
      out_ready <= rand_ready ? (($urandom % 8) == 0) : 1'b1; // Ready one cycle in eight
   end

   function automatic bus_word_t adr_of(input logic [1:0] region, input logic [5:0] ofs);
      return {10'd0, region, 14'd0, ofs};          // Region in adr[21:20]
   endfunction

   // Leaves the request up so that a following access runs back to back
   task automatic bus_access(input logic we, input bus_word_t adr, input bus_word_t dat,
                             output bus_word_t rdat);
      @(negedge clk);
      bus_req.adr = adr;
      bus_req.dat = dat;
      bus_req.we  = we;
      bus_req.cyc = 1'b1;
      bus_req.stb = 1'b1;
      @(posedge clk);
      while (!(bus_rsp.ack || bus_rsp.err)) begin
         @(posedge clk);                           // Stalled send write
      end
      rdat = bus_rsp.dat;
   endtask

   task automatic bus_idle();
      @(negedge clk);
      bus_req.cyc = 1'b0;
      bus_req.stb = 1'b0;
      bus_req.we  = 1'b0;
   endtask

   task automatic send_packet(input int n);
      bus_word_t unused;
      bus_access(1'b1, adr_of(2'd1, 6'h00), bus_word_t'(n), unused); // Size word
      for (int k = 0; k < n; k++) begin
         bus_access(1'b1, adr_of(2'd1, 6'h00), $urandom, unused);
      end
   endtask

   task automatic link_packet(input int n);
      for (int k = 0; k < n; k++) begin
         @(negedge clk);
         in_valid     = 1'b1;
         in_flit.data = $urandom;
         if (n == 1) begin
            in_flit.ftype = FLIT_SINGLE;
         end else if (k == 0) begin
            in_flit.ftype = FLIT_HEADER;
         end else if (k == n - 1) begin
            in_flit.ftype = FLIT_LAST;
         end else begin
            in_flit.ftype = FLIT_PAYLOAD;
         end
         @(posedge clk);
         while (!in_ready) begin
            @(posedge clk);
         end
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   task automatic drain_link();
      while (out_valid) begin
         @(posedge clk);
      end
   endtask

   task automatic end_test(input logic [2:0] num);
      @(negedge clk);
      test_num = num;
      test_end = 1'b1;                             // Checker reports at next edge
      @(negedge clk);
      test_end = 1'b0;
   endtask

   initial begin
      int        total;
      int        n;
      bus_word_t word;
      bus_req    = '0;
      in_flit    = '0;
      in_valid   = 1'b0;
      rand_ready = 1'b0;
      test_end   = 1'b0;
      test_num   = '0;
      rst        = 1'b1;
      void'($urandom(32'hecd1_7521));
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < 6; i++) begin
         bus_access(1'b0, adr_of(2'd0, 6'(4 * i)), '0, word); // 0x00 to 0x14
      end
      bus_access(1'b0, adr_of(2'd0, 6'h3C), '0, word);
      bus_access(1'b1, adr_of(2'd0, 6'h00), 32'hffff_ffff, word); // Read-only block
      bus_access(1'b0, adr_of(2'd0, 6'h00), '0, word);
      bus_idle();
      end_test(3'd1);

      bus_access(1'b1, adr_of(2'd1, 6'h00), 32'd0, word);  // Bad sizes are dropped
      bus_access(1'b1, adr_of(2'd1, 6'h00), 32'd17, word);
      send_packet(1);
      send_packet(2);
      send_packet(5);
      bus_idle();
      drain_link();
      end_test(3'd2);

      @(posedge clk);
      rand_ready = 1'b1;
      send_packet(16);
      send_packet(16);                             // Second packet meets a full FIFO
      bus_idle();
      drain_link();
      @(posedge clk);
      rand_ready = 1'b0;
      end_test(3'd3);

      total = 0;
      for (int p = 0; p < 3; p++) begin
         n = 1 + int'($urandom % 5);
         link_packet(n);
         total += n + 1;                           // Size word plus data words
      end
      while (!irq) begin
         @(posedge clk);
      end
      for (int i = 0; i < total; i++) begin
         bus_access(1'b0, adr_of(2'd1, 6'h00), '0, word);
      end
      bus_idle();
      end_test(3'd4);

      bus_access(1'b0, adr_of(2'd1, 6'h00), '0, word);
      bus_access(1'b0, adr_of(2'd1, 6'h00), '0, word);
      bus_idle();
      end_test(3'd5);

      bus_access(1'b0, adr_of(2'd2, 6'h00), '0, word);
      bus_access(1'b1, adr_of(2'd2, 6'h04), 32'h1234_5678, word);
      bus_access(1'b0, adr_of(2'd3, 6'h00), '0, word);
      bus_access(1'b1, adr_of(2'd3, 6'h10), 32'h8765_4321, word);
      bus_idle();
      end_test(3'd6);

      @(negedge clk);
      $display("tests 6, checks %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: testbench/na_ct_asserts.sv
// Concurrent assertions on bus response, link output hold and interrupt after reset
`timescale 1ns/1ps

module na_ct_asserts (
   input logic             clk,
   input logic             rst_i,
   input na_pkg::bus_rsp_t bus_rsp_i,
   input na_pkg::flit_t    out_flit_i,
   input logic             out_valid_i,
   input logic             out_ready_i,
   input logic             irq_i
);

   ack_err_excl: assert property (@(posedge clk) disable iff (rst_i)
      !(bus_rsp_i.ack && bus_rsp_i.err))
      else $error("ack and err high in the same cycle");

   out_hold: assert property (@(posedge clk) disable iff (rst_i)
      (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_flit_i)))
      else $error("link output flit changed or dropped before transfer");

   irq_after_reset: assert property (@(posedge clk) rst_i |=> !irq_i)
      else $error("interrupt high in the cycle after reset");

endmodule

bind na_ct_top na_ct_asserts u_asserts (
   .clk         (clk),
   .rst_i       (rst_i),
   .bus_rsp_i   (bus_rsp_o),
   .out_flit_i  (noc_out_flit_o),
   .out_valid_i (noc_out_valid_o),
   .out_ready_i (noc_out_ready_i),
   .irq_i       (irq_o)
);

// File: testbench/tb_checker.sv
// Reference flit and register model, bus and link comparison, per-test report and counts
`timescale 1ns/1ps

module tb_checker (
   input  logic             clk,
   input  logic             rst_i,
   input  na_pkg::bus_req_t bus_req_i,
   input  na_pkg::bus_rsp_t bus_rsp_i,
   input  na_pkg::flit_t    out_flit_i,
   input  logic             out_valid_i,
   input  logic             out_ready_i,
   input  na_pkg::flit_t    in_flit_i,
   input  logic             in_valid_i,
   input  logic             in_ready_i,
   input  logic             irq_i,
   input  logic             test_end_i,
   input  logic [2:0]       test_num_i,
   output int               err_cnt_o,
   output int               chk_cnt_o
);

   import na_pkg::*;

   flit_t       tx_q[$];                           // Flits owed on the link output
   bus_word_t   rx_pkt[$];                         // Packet still arriving on link input
   logic [32:0] rx_q[$];                           // Read stream, bit 32 marks a size
   int          tx_size   = 0;
   int          tx_left   = 0;                     // Zero when no send packet is open
   int          rx_sizes  = 0;                     // Complete packets not yet opened
   int          rx_held   = 0;                     // Flits held in the receive FIFO
   int          err_cnt   = 0;
   int          chk_cnt   = 0;
   int          test_errs = 0;
   int          stalls    = 0;
   logic [1:0]  region;
   logic        acc;

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

   // Expected flit for word k of a packet of n words
   function automatic flit_t flit_ref(input int n, input int k, input bus_word_t word);
      flit_t f;
      if (n == 1) begin
         f.ftype = FLIT_SINGLE;
      end else if (k == 0) begin
         f.ftype = FLIT_HEADER;
      end else if (k == n - 1) begin
         f.ftype = FLIT_LAST;
      end else begin
         f.ftype = FLIT_PAYLOAD;
      end
      f.data = word;
      return f;
   endfunction

   function automatic bus_word_t conf_ref(input logic [5:0] ofs);
      case (ofs)
         6'h00:   return TILE_ID;
         6'h04:   return NOC_XDIM;
         6'h08:   return NOC_YDIM;
         6'h0C:   return NUM_CORES;
         6'h10:   return FEATURE_FLAGS;
         default: return '0;
      endcase
   endfunction

   function automatic string test_name(input logic [2:0] num);
      case (num)
         3'd1:    return "config registers";
         3'd2:    return "send packets";
         3'd3:    return "send under back-pressure";
         3'd4:    return "receive packets";
         3'd5:    return "receive empty";
         3'd6:    return "unmapped regions";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_value(input string name, input bus_word_t got, input bus_word_t exp);
      chk_cnt++;
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         err_cnt++;
         test_errs++;
      end
   endtask

   task automatic report_fault(input string msg);
      $display("%s", msg);
      err_cnt++;
      test_errs++;
   endtask

   task automatic tx_write(input bus_word_t word);
      if (tx_left == 0) begin
         if (word >= 1 && word <= 16) begin        // Other sizes open nothing
            tx_size = int'(word);
            tx_left = int'(word);
         end
      end else begin
         tx_q.push_back(flit_ref(tx_size, tx_size - tx_left, word));
         tx_left--;
      end
   endtask

   always @(posedge clk) begin
      flit_t       exp;
      logic [32:0] item;
      if (!rst_i) begin
         region = bus_req_i.adr[21:20];
         acc    = bus_req_i.cyc & bus_req_i.stb;
         check_value("irq_o", 32'(irq_i), 32'(rx_sizes != 0));
         // Ready drops only when either receive FIFO is full
         check_value("noc_in_ready_o", 32'(in_ready_i),
                     32'(rx_held < FLIT_DEPTH && rx_sizes < SIZE_DEPTH));
         if (!acc) begin
            check_value("bus_rsp.ack", 32'(bus_rsp_i.ack), 32'd0);
            check_value("bus_rsp.err", 32'(bus_rsp_i.err), 32'd0);
         end else if (region >= 2'd2) begin
            check_value("bus_rsp.err", 32'(bus_rsp_i.err), 32'd1);
            check_value("bus_rsp.ack", 32'(bus_rsp_i.ack), 32'd0);
         end else begin
            check_value("bus_rsp.err", 32'(bus_rsp_i.err), 32'd0);
            if (region == 2'd0) begin
               check_value("bus_rsp.ack", 32'(bus_rsp_i.ack), 32'd1);
               if (!bus_req_i.we) begin
                  check_value("bus_rsp.dat", bus_rsp_i.dat, conf_ref(bus_req_i.adr[5:0]));
               end
            end else if (bus_req_i.we) begin
               if (bus_rsp_i.ack) begin
                  tx_write(bus_req_i.dat);
               end else begin
                  stalls++;                        // Write held by a full FIFO
               end
            end else begin
               check_value("bus_rsp.ack", 32'(bus_rsp_i.ack), 32'd1);
               item = '0;                          // Nothing queued reads as 0
               if (rx_q.size() != 0) begin
                  item = rx_q.pop_front();
                  if (item[32]) begin
                     rx_sizes--;
                  end else begin
                     rx_held--;
                  end
               end
               check_value("bus_rsp.dat", bus_rsp_i.dat, item[31:0]);
            end
         end
         if (out_valid_i && out_ready_i) begin
            if (tx_q.size() == 0) begin
               report_fault("a flit left on the link output with no word written for it");
            end else begin
               exp = tx_q.pop_front();
               check_value("noc_out_flit.ftype", 32'(out_flit_i.ftype), 32'(exp.ftype));
               check_value("noc_out_flit.data", out_flit_i.data, exp.data);
            end
         end
         if (in_valid_i && in_ready_i) begin
            rx_pkt.push_back(in_flit_i.data);
            rx_held++;
            if (in_flit_i.ftype == FLIT_LAST || in_flit_i.ftype == FLIT_SINGLE) begin
               rx_q.push_back({1'b1, 32'(rx_pkt.size())});
               foreach (rx_pkt[i]) begin
                  rx_q.push_back({1'b0, rx_pkt[i]});
               end
               rx_pkt.delete();
               rx_sizes++;
            end
         end
         if (test_end_i) begin
            if (tx_q.size() != 0) begin
               report_fault($sformatf("%0d written flits never left the link", tx_q.size()));
            end
            if (rx_q.size() != 0) begin
               report_fault($sformatf("%0d received words were never read", rx_q.size()));
            end
            if (test_num_i == 3'd3 && stalls == 0) begin
               report_fault("send writes never stalled under link back-pressure");
            end
            $display("test %0d %s: %s", test_num_i, test_name(test_num_i),
                     (test_errs == 0) ? "ok" : "failed");
            test_errs = 0;
            stalls    = 0;
         end
      end
   end

endmodule

// File: src/na_ct_top.sv
// Compute-tile network adapter top with bus control, config registers and MP paths
`timescale 1ns/1ps

module na_ct_top (
   input  logic              clk,
   input  logic              rst_i,
   input  na_pkg::bus_req_t  bus_req_i,
   output na_pkg::bus_rsp_t  bus_rsp_o,
   output na_pkg::flit_t     noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,
   input  na_pkg::flit_t     noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output logic              irq_o
);

   import na_pkg::*;

   logic [REG_OFS_W-1:0] reg_ofs;
   bus_word_t            conf_rdat;
   bus_word_t            rx_rdat;
   logic                 tx_wr;
   logic                 tx_wr_ready;
   logic                 rx_rd;

   na_bus_ctrl u_bus_ctrl (
      .clk           (clk),
      .rst_i         (rst_i),
      .bus_req_i     (bus_req_i),
      .bus_rsp_o     (bus_rsp_o),
      .reg_ofs_o     (reg_ofs),
      .conf_rdat_i   (conf_rdat),
      .tx_wr_o       (tx_wr),
      .tx_wr_ready_i (tx_wr_ready),
      .rx_rd_o       (rx_rd),
      .rx_rdat_i     (rx_rdat)
   );

   na_conf_regs u_conf_regs (
      .reg_ofs_i (reg_ofs),
      .rdat_o    (conf_rdat)
   );

   mp_tx u_mp_tx (
      .clk             (clk),
      .rst_i           (rst_i),
      .wr_i            (tx_wr),
      .wr_dat_i        (bus_req_i.dat),            // Word straight from the bus
      .wr_ready_o      (tx_wr_ready),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

   mp_rx u_mp_rx (
      .clk            (clk),
      .rst_i          (rst_i),
      .noc_in_flit_i  (noc_in_flit_i),
      .noc_in_valid_i (noc_in_valid_i),
      .noc_in_ready_o (noc_in_ready_o),
      .rd_i           (rx_rd),
      .rdat_o         (rx_rdat),
      .irq_o          (irq_o)
   );

endmodule

// File: src/mp_rx.sv
// Message receive path queuing packets and their sizes for bus readback
`timescale 1ns/1ps

module mp_rx (
   input  logic              clk,
   input  logic              rst_i,
   input  na_pkg::flit_t     noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   input  logic              rd_i,                 // Bus read, completes now
   output na_pkg::bus_word_t rdat_o,
   output logic              irq_o                 // Packet waiting
);

   import na_pkg::*;

   logic [SIZE_W-1:0] in_cnt_q;                    // Flits of packet being received
   logic [SIZE_W-1:0] rd_remain_q;                 // Words left in packet being read
   logic [SIZE_W-1:0] size_push_dat;
   logic [SIZE_W-1:0] size_head;
   flit_t             flit_head;
   logic              accept;
   logic              is_end;
   logic              pkt_open;
   logic              flit_pop;
   logic              size_pop;
   logic              flit_empty;
   logic              flit_full;
   logic              size_empty;
   logic              size_full;

   assign noc_in_ready_o = ~flit_full & ~size_full;
   assign accept         = noc_in_valid_i & noc_in_ready_o;
   assign is_end         = (noc_in_flit_i.ftype == FLIT_LAST) |
                           (noc_in_flit_i.ftype == FLIT_SINGLE);
   assign size_push_dat  = in_cnt_q + 1'b1;        // Count includes closing flit

   assign pkt_open = (rd_remain_q != '0);
   assign size_pop = rd_i & ~pkt_open & ~size_empty; // Size word opens a packet
   assign flit_pop = rd_i & pkt_open & ~flit_empty;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         in_cnt_q <= '0;
      end else if (accept) begin
         in_cnt_q <= is_end ? '0 : in_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         rd_remain_q <= '0;
      end else if (size_pop) begin
         rd_remain_q <= size_head;
      end else if (flit_pop) begin
         rd_remain_q <= rd_remain_q - 1'b1;
      end
   end

   always_comb begin
      if (pkt_open) begin
         rdat_o = flit_head.data;
      end else if (!size_empty) begin
         rdat_o = bus_word_t'(size_head);          // Zero-extended size
      end else begin
         rdat_o = '0;                              // Nothing queued
      end
   end

   na_fifo #(
      .payload_t (flit_t),
      .DEPTH     (FLIT_DEPTH)
   ) u_flit_fifo (
      .clk        (clk),
      .rst_i      (rst_i),
      .push_i     (accept),
      .push_dat_i (noc_in_flit_i),
      .pop_i      (flit_pop),
      .head_o     (flit_head),
      .empty_o    (flit_empty),
      .full_o     (flit_full)
   );

   na_fifo #(
      .payload_t (logic [SIZE_W-1:0]),
      .DEPTH     (SIZE_DEPTH)
   ) u_size_fifo (
      .clk        (clk),
      .rst_i      (rst_i),
      .push_i     (accept & is_end),               // Whole packet now stored
      .push_dat_i (size_push_dat),
      .pop_i      (size_pop),
      .head_o     (size_head),
      .empty_o    (size_empty),
      .full_o     (size_full)
   );

   assign irq_o = ~size_empty;

endmodule

// File: src/mp_tx.sv
// Message send path turning bus words into typed flits on the NoC link
`timescale 1ns/1ps

module mp_tx (
   input  logic              clk,
   input  logic              rst_i,
   input  logic              wr_i,                 // Word write, completes now
   input  na_pkg::bus_word_t wr_dat_i,
   output logic              wr_ready_o,           // Low while a flit finds FIFO full
   output na_pkg::flit_t     noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i
);

   import na_pkg::*;

   logic [SIZE_W-1:0] remain_q;                    // Flits still owed to open packet
   logic              first_q;                     // Next flit opens the packet
   logic              pkt_open;
   logic              size_ok;
   logic              push;
   logic              fifo_empty;
   logic              fifo_full;
   flit_t             push_flit;

   assign pkt_open   = (remain_q != '0);
   assign size_ok    = (wr_dat_i != '0) && (wr_dat_i <= FLIT_DEPTH);
   assign push       = wr_i & pkt_open;            // Size words are not flits
   assign wr_ready_o = ~(pkt_open & fifo_full);

   always_comb begin
      if (first_q) begin
         push_flit.ftype = (remain_q == SIZE_W'(1)) ? FLIT_SINGLE : FLIT_HEADER;
      end else begin
         push_flit.ftype = (remain_q == SIZE_W'(1)) ? FLIT_LAST : FLIT_PAYLOAD;
      end
      push_flit.data = wr_dat_i;
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         remain_q <= '0;
         first_q  <= 1'b0;
      end else if (wr_i) begin
         if (!pkt_open) begin
            if (size_ok) begin                     // Bad sizes leave no packet open
               remain_q <= wr_dat_i[SIZE_W-1:0];
               first_q  <= 1'b1;
            end
         end else begin
            remain_q <= remain_q - 1'b1;
            first_q  <= 1'b0;
         end
      end
   end

   na_fifo #(
      .payload_t (flit_t),
      .DEPTH     (FLIT_DEPTH)
   ) u_flit_fifo (
      .clk        (clk),
      .rst_i      (rst_i),
      .push_i     (push),
      .push_dat_i (push_flit),
      .pop_i      (noc_out_valid_o & noc_out_ready_i), // Link handshake
      .head_o     (noc_out_flit_o),
      .empty_o    (fifo_empty),
      .full_o     (fifo_full)
   );

   assign noc_out_valid_o = ~fifo_empty;           // Head held until taken

endmodule

// File: src/na_bus_ctrl.sv
// Bus slave region decode, strobe generation and response multiplexing
`timescale 1ns/1ps

module na_bus_ctrl (
   input  logic                           clk,
   input  logic                           rst_i,
   input  na_pkg::bus_req_t               bus_req_i,
   output na_pkg::bus_rsp_t               bus_rsp_o,
   output logic [na_pkg::REG_OFS_W-1:0]   reg_ofs_o,     // Config register offset
   input  na_pkg::bus_word_t              conf_rdat_i,
   output logic                           tx_wr_o,       // Send word, completes now
   input  logic                           tx_wr_ready_i,
   output logic                           rx_rd_o,       // Receive read, completes now
   input  na_pkg::bus_word_t              rx_rdat_i
);

   import na_pkg::*;

   region_e   region;
   logic      acc;                                 // Live access this cycle
   logic      mp_wr;
   logic      mp_rd;
   logic      ack;
   logic      err;
   bus_word_t rdat_sel;                            // Data of the selected region
   bus_word_t rdat_q;                              // Last completed read data

   always_comb begin
      case (bus_req_i.adr[REGION_LSB +: 2])
         2'b00:   region = REGION_CONF;
         2'b01:   region = REGION_MP;
         default: region = REGION_UNMAPPED;        // 2 and 3 have no slave
      endcase
   end

   assign acc       = bus_req_i.cyc & bus_req_i.stb;
   assign mp_wr     = acc & (region == REGION_MP) & bus_req_i.we;
   assign mp_rd     = acc & (region == REGION_MP) & ~bus_req_i.we;
   assign reg_ofs_o = bus_req_i.adr[REG_OFS_W-1:0];

   assign tx_wr_o = mp_wr & tx_wr_ready_i;         // Stalls while TX FIFO is full
   assign rx_rd_o = mp_rd;                         // Reads never stall

   // Config writes are acked and dropped, the block is read-only
   assign ack = (acc & (region == REGION_CONF)) | tx_wr_o | rx_rd_o;
   assign err = acc & (region == REGION_UNMAPPED);

   always_comb begin
      case (region)
         REGION_CONF: rdat_sel = conf_rdat_i;
         REGION_MP:   rdat_sel = rx_rdat_i;
         default:     rdat_sel = '0;
      endcase
   end

   // Keeps dat lines quiet between accesses instead of following FIFO heads
   always_ff @(posedge clk) begin
      if (rst_i) begin
         rdat_q <= '0;
      end else if (ack) begin
         rdat_q <= rdat_sel;
      end
   end

   assign bus_rsp_o.dat = ack ? rdat_sel : rdat_q;
   assign bus_rsp_o.ack = ack;
   assign bus_rsp_o.err = err;

endmodule

// File: src/na_conf_regs.sv
// Read-only tile configuration registers
`timescale 1ns/1ps

module na_conf_regs (
   input  logic [na_pkg::REG_OFS_W-1:0] reg_ofs_i,  // Word-aligned offset
   output na_pkg::bus_word_t            rdat_o
);

   import na_pkg::*;

   always_comb begin
      case (reg_ofs_i)
         OFS_TILE_ID:  rdat_o = TILE_ID;
         OFS_XDIM:     rdat_o = NOC_XDIM;            // Mesh width
         OFS_YDIM:     rdat_o = NOC_YDIM;            // Mesh height
         OFS_CORES:    rdat_o = NUM_CORES;
         OFS_FEATURES: rdat_o = FEATURE_FLAGS;       // MP only, no DMA
         default:      rdat_o = '0;                  // Unused offsets
      endcase
   end

endmodule

// File: src/na_fifo.sv
// Synchronous register-array FIFO with a type-parameter payload
`timescale 1ns/1ps

module na_fifo #(
   parameter type payload_t = logic [31:0],        // Stored item
   parameter int  DEPTH     = 4                    // Entries, power of two
) (
   input  logic     clk,
   input  logic     rst_i,
   input  logic     push_i,
   input  payload_t push_dat_i,
   input  logic     pop_i,
   output payload_t head_o,                        // Oldest entry, valid when not empty
   output logic     empty_o,
   output logic     full_o
);

   payload_t                 mem [DEPTH];          // Storage array
   logic [$clog2(DEPTH)-1:0] wr_ptr_q;             // Wraps naturally at DEPTH
   logic [$clog2(DEPTH)-1:0] rd_ptr_q;
   logic [$clog2(DEPTH):0]   count_q;              // 0 .. DEPTH
   logic                     do_push;
   logic                     do_pop;

   assign empty_o = (count_q == '0);
   assign full_o  = (int'(count_q) == DEPTH);
   assign head_o  = mem[rd_ptr_q];                 // Show-ahead read
   assign do_push = push_i & ~full_o;              // Drop push on full
   assign do_pop  = pop_i & ~empty_o;              // Ignore pop on empty

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= push_dat_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;           // Both or neither
         endcase
      end
   end

endmodule

// File: src/na_pkg.sv
// Flit, bus and region types, FIFO sizes, register offsets and tile configuration values
package na_pkg;

   typedef logic [31:0] bus_word_t;                // Bus address or data word

   typedef enum logic [1:0] {
      FLIT_PAYLOAD = 2'b00,                        // Inside a packet
      FLIT_HEADER  = 2'b01,                        // Opens a multi-flit packet
      FLIT_LAST    = 2'b10,                        // Closes a multi-flit packet
      FLIT_SINGLE  = 2'b11                         // Packet of one flit
   } flit_type_e;

   typedef struct packed {
      flit_type_e ftype;                           // Position in packet
      bus_word_t  data;
   } flit_t;                                       // 34 bits on the link

   typedef struct packed {
      bus_word_t adr;
      bus_word_t dat;                              // Write data
      logic      we;
      logic      cyc;
      logic      stb;
   } bus_req_t;                                    // 67 bits, master to slave

   typedef struct packed {
      bus_word_t dat;                              // Read data, valid with ack
      logic      ack;
      logic      err;
   } bus_rsp_t;                                    // 34 bits, slave to master

   typedef enum logic [1:0] {
      REGION_CONF     = 2'd0,                      // Tile configuration
      REGION_MP       = 2'd1,                      // Message passing
      REGION_UNMAPPED = 2'd2                       // Regions 2 and 3
   } region_e;

   localparam int unsigned REGION_LSB = 20;        // Region field is adr[21:20]
   localparam int unsigned FLIT_DEPTH = 16;        // Flit FIFO depth, max packet size
   localparam int unsigned SIZE_DEPTH = 4;         // Queued received packets
   localparam int unsigned SIZE_W     = 5;         // Holds sizes up to 16
   localparam int unsigned REG_OFS_W  = 6;         // Offset inside a region

   localparam logic [REG_OFS_W-1:0] OFS_TILE_ID  = 6'h00;
   localparam logic [REG_OFS_W-1:0] OFS_XDIM     = 6'h04;
   localparam logic [REG_OFS_W-1:0] OFS_YDIM     = 6'h08;
   localparam logic [REG_OFS_W-1:0] OFS_CORES    = 6'h0C;
   localparam logic [REG_OFS_W-1:0] OFS_FEATURES = 6'h10;

   localparam logic [31:0] TILE_ID       = 32'd5;
   localparam logic [31:0] NOC_XDIM      = 32'd4;
   localparam logic [31:0] NOC_YDIM      = 32'd2;
   localparam logic [31:0] NUM_CORES     = 32'd8;
   localparam logic [31:0] FEATURE_FLAGS = 32'h0000_0001; // Bit 0 MP present, bit 1 DMA absent

endpackage
